//--- obuf_bias_pkg.sv
// ====================================================================
// obuf bias select package
// widths, table depth, seed address and the accumulator seed source
// ====================================================================

package obuf_bias_pkg;

  // ====================================================================
  // address widths
  // ====================================================================

  // output tile base address
  localparam int TILE_ADDR_W = 42;
  // output buffer load address
  localparam int OBUF_ADDR_W = 8;
  // bias buffer load address
  localparam int BBUF_ADDR_W = 8;

  // loop id carried with each loop-iteration config
  localparam int LOOP_ID_W = 5;
  // layer count, wide enough for a whole program
  localparam int LAYER_W = 8;

  // ====================================================================
  // bias address history
  // ====================================================================

  localparam int HIST_DEPTH = 32;
  localparam int HIST_PTR_W = 5;

  // entry 0 after reset or a round clear
  localparam logic [BBUF_ADDR_W-1:0] HIST_SEED_ADDR = 8'd20;

  // tile-repeat flag queue
  localparam int REPEAT_FIFO_DEPTH = 4;

  // ====================================================================
  // accumulator seed source
  // ====================================================================

  typedef enum logic {
    // seed from bias buffer
    SEL_BIAS = 1'b0,
    // seed from partial sums in the output buffer
    SEL_OBUF = 1'b1
  } sel_src_e;

endpackage

//--- tile_repeat_fifo.sv
// ====================================================================
// tile repeat fifo
// small synchronous circular buffer with a registered read port
// ====================================================================
`timescale 1ns/1ns

module tile_repeat_fifo #(
  parameter int data_w = 1,
  parameter int depth  = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              push,
  input  logic [data_w-1:0] push_data,
  input  logic              pop,
  output logic [data_w-1:0] pop_data,
  output logic              empty,
  output logic              full
);

  logic [data_w-1:0]          mem [depth];
  logic [$clog2(depth)-1:0]   wr_ptr;
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic [$clog2(depth+1)-1:0] count;
  logic                       push_ok;
  logic                       pop_ok;

  // a push into a full buffer is dropped
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;

  assign empty = (count == 0);
  assign full  = (count == depth);

  // storage, no reset
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap at depth, any depth works
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // read data held until the next pop
  always_ff @(posedge clk) begin
    if (reset) begin
      pop_data <= '0;
    end else if (pop_ok) begin
      pop_data <= mem[rd_ptr];
    end
  end

endmodule

//--- tile_repeat_tracker.sv
// ====================================================================
// tile repeat tracker
// queues one repeat flag per output tile, pops one per compute done
// ====================================================================
`timescale 1ns/1ns

module tile_repeat_tracker import obuf_bias_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   compute_done,
  input  logic                   i_decoder_done,
  input  logic                   cfg_loop_iter_v,
  input  logic [TILE_ADDR_W-1:0] obuf_tile_base_addr,
  input  logic                   obuf_tile_base_addr_v,
  output logic                   tile_repeat,
  output logic                   pop_valid
);

  logic [TILE_ADDR_W-1:0] last_tile_base;
  logic                   flag_push;
  logic                   flag_data;
  logic                   flag_pop;
  logic                   fifo_empty;

  // ====================================================================
  // last tile base
  // ====================================================================

  // zero marks "no previous tile" in this program or loop config
  always_ff @(posedge clk) begin
    if (reset) begin
      last_tile_base <= '0;
    end else if (i_decoder_done || cfg_loop_iter_v) begin
      last_tile_base <= '0;
    end else if (obuf_tile_base_addr_v) begin
      last_tile_base <= obuf_tile_base_addr;
    end
  end

  // first tile after a clear queues nothing
  assign flag_push = obuf_tile_base_addr_v && (last_tile_base != '0);
  // same base again means partial sums can be reused
  assign flag_data = (obuf_tile_base_addr == last_tile_base);

  // ====================================================================
  // flag queue
  // ====================================================================

  assign flag_pop = compute_done && !fifo_empty;

  tile_repeat_fifo #(
    .data_w (1),
    .depth  (REPEAT_FIFO_DEPTH)
  ) u_repeat_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (flag_push),
    .push_data (flag_data),
    .pop       (flag_pop),
    .pop_data  (tile_repeat),
    .empty     (fifo_empty),
    .full      ()
  );

  // marks the cycle tile_repeat is looked at, even on an empty pop
  always_ff @(posedge clk) begin
    if (reset) begin
      pop_valid <= 1'b0;
    end else begin
      pop_valid <= compute_done;
    end
  end

endmodule

//--- bias_addr_history.sv
// ====================================================================
// bias address history
// records bias load addresses of a round, matches output load addresses
// ====================================================================
`timescale 1ns/1ns

module bias_addr_history import obuf_bias_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_decoder_done,
  input  logic                   cfg_loop_iter_v,
  input  logic                   round_clear,
  input  logic [BBUF_ADDR_W-1:0] bias_ld_addr,
  input  logic                   base_loop_enter,
  input  logic [OBUF_ADDR_W-1:0] obuf_ld_addr,
  input  logic                   obuf_ld_addr_v,
  output logic                   record_req,
  output logic                   addr_hit,
  output logic                   late_hit
);

  logic [BBUF_ADDR_W-1:0] last_bias_addr;
  logic                   base_loop_enter_d;
  logic                   fresh_round;
  logic                   new_bias_addr;
  logic [HIST_PTR_W-1:0]  wr_ptr;
  logic [HIST_PTR_W-1:0]  rd_ptr;
  logic [BBUF_ADDR_W-1:0] addr_table [HIST_DEPTH];
  logic [BBUF_ADDR_W-1:0] newest_addr;
  logic                   record_req_d;
  logic [OBUF_ADDR_W-1:0] obuf_ld_addr_d;

  // ====================================================================
  // round tracking
  // ====================================================================

  // bias address sampled every cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      last_bias_addr <= '0;
    end else if (i_decoder_done || cfg_loop_iter_v) begin
      last_bias_addr <= '0;
    end else begin
      last_bias_addr <= bias_ld_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      base_loop_enter_d <= 1'b0;
    end else begin
      base_loop_enter_d <= base_loop_enter;
    end
  end

  assign new_bias_addr = (bias_ld_addr != last_bias_addr);

  // armed by a new round or a moving bias address, spent by a record
  always_ff @(posedge clk) begin
    if (reset) begin
      fresh_round <= 1'b0;
    end else if (round_clear || new_bias_addr) begin
      fresh_round <= 1'b1;
    end else if (record_req) begin
      fresh_round <= 1'b0;
    end
  end

  // bias address lines up with the next free slot
  assign record_req = fresh_round && base_loop_enter_d &&
                      ({{(BBUF_ADDR_W - HIST_PTR_W){1'b0}}, wr_ptr} == bias_ld_addr);

  // ====================================================================
  // address table
  // ====================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (round_clear) begin
      wr_ptr <= '0;
    end else if (record_req) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // newest entry, slot 0 while nothing recorded
  assign rd_ptr = (wr_ptr == '0) ? '0 : wr_ptr - 1'b1;

  // only entry 0 is seeded, the rest is written before it is read
  always_ff @(posedge clk) begin
    if (reset) begin
      addr_table[0] <= HIST_SEED_ADDR;
    end else if (round_clear) begin
      addr_table[0] <= HIST_SEED_ADDR;
    end else if (record_req) begin
      addr_table[wr_ptr] <= bias_ld_addr;
    end
  end

  assign newest_addr = addr_table[rd_ptr];

  // ====================================================================
  // output load matching
  // ====================================================================

  // first or newest recorded address
  assign addr_hit = (obuf_ld_addr == addr_table[0]) || (obuf_ld_addr == newest_addr);

  always_ff @(posedge clk) begin
    if (reset) begin
      record_req_d   <= 1'b0;
      obuf_ld_addr_d <= '0;
    end else begin
      record_req_d   <= record_req;
      obuf_ld_addr_d <= obuf_ld_addr;
    end
  end

  // load address seen just as the record landed in the table
  assign late_hit = record_req_d && (obuf_ld_addr_d == newest_addr) && obuf_ld_addr_v;

endmodule

//--- layer_counter.sv
// ====================================================================
// layer counter
// counts outer-loop configs in a program and flags layer one
// ====================================================================
`timescale 1ns/1ns

module layer_counter import obuf_bias_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_decoder_done,
  input  logic                 cfg_loop_iter_v,
  input  logic [LOOP_ID_W-1:0] cfg_loop_iter_loop_id,
  output logic                 layer_one
);

  logic [LAYER_W-1:0] layer_count;
  logic               outer_cfg;

  // loop id 0 opens a new layer
  assign outer_cfg = cfg_loop_iter_v && (cfg_loop_iter_loop_id == '0);

  // increment wins over the program-end clear
  always_ff @(posedge clk) begin
    if (reset) begin
      layer_count <= '0;
    end else if (outer_cfg) begin
      layer_count <= layer_count + 1'b1;
    end else if (i_decoder_done) begin
      layer_count <= '0;
    end
  end

  // first layer has no partial sums to reuse
  assign layer_one = (layer_count == LAYER_W'(1));

endmodule

//--- bias_sel_fsm.sv
// ====================================================================
// bias select controller
// select state and skip flag, drives the accumulator seed source
// ====================================================================
`timescale 1ns/1ns

module bias_sel_fsm import obuf_bias_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     tile_repeat,
  input  logic     pop_valid,
  input  logic     record_req,
  input  logic     addr_hit,
  input  logic     late_hit,
  input  logic     obuf_ld_addr_v,
  input  logic     layer_one,
  input  logic     cfg_loop_iter_v,
  output logic     round_clear,
  output sel_src_e obuf_bias_sel_out
);

  sel_src_e sel_state;
  logic     skip;
  logic     block_end;

  // ====================================================================
  // block end and round clear
  // ====================================================================

  // popped flag says new tile, so a new accumulation block starts
  assign block_end   = pop_valid && !tile_repeat;
  assign round_clear = block_end || cfg_loop_iter_v;

  // ====================================================================
  // skip flag
  // ====================================================================

  // one-shot after a record, cleared by a valid matching load
  always_ff @(posedge clk) begin
    if (reset) begin
      skip <= 1'b0;
    end else if (obuf_ld_addr_v && (addr_hit || late_hit)) begin
      skip <= 1'b0;
    end else if (record_req) begin
      skip <= 1'b1;
    end
  end

  // ====================================================================
  // select state
  // ====================================================================

  // priority: clear/record, then popped flag, then address hit
  always_ff @(posedge clk) begin
    if (reset) begin
      sel_state <= SEL_BIAS;
    end else if (round_clear || record_req) begin
      sel_state <= SEL_BIAS;
    end else if (pop_valid) begin
      // repeat flag maps straight onto the seed source
      sel_state <= sel_src_e'(tile_repeat);
    end else if (addr_hit && !skip) begin
      sel_state <= SEL_OBUF;
    end
  end

  // layer one always seeds from bias
  assign obuf_bias_sel_out = layer_one ? SEL_BIAS : sel_state;

endmodule

//--- obuf_bias_sel.sv
// ====================================================================
// obuf bias select top
// chooses bias or output buffer as the accumulator seed, per cycle
// ====================================================================
`timescale 1ns/1ns

module obuf_bias_sel import obuf_bias_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   compute_done,
  input  logic                   i_decoder_done,
  input  logic                   cfg_loop_iter_v,
  input  logic [LOOP_ID_W-1:0]   cfg_loop_iter_loop_id,
  input  logic [TILE_ADDR_W-1:0] obuf_tile_base_addr,
  input  logic                   obuf_tile_base_addr_v,
  input  logic [BBUF_ADDR_W-1:0] bias_ld_addr,
  input  logic                   base_loop_enter,
  input  logic [OBUF_ADDR_W-1:0] obuf_ld_addr,
  input  logic                   obuf_ld_addr_v,
  output sel_src_e               obuf_bias_sel_out
);

  // tracker to controller
  logic tile_repeat;
  logic pop_valid;
  // history to controller
  logic record_req;
  logic addr_hit;
  logic late_hit;
  // controller to history
  logic round_clear;
  logic layer_one;

  // tile repeat flags, one per tile base
  tile_repeat_tracker u_tracker (
    .clk                   (clk),
    .reset                 (reset),
    .compute_done          (compute_done),
    .i_decoder_done        (i_decoder_done),
    .cfg_loop_iter_v       (cfg_loop_iter_v),
    .obuf_tile_base_addr   (obuf_tile_base_addr),
    .obuf_tile_base_addr_v (obuf_tile_base_addr_v),
    .tile_repeat           (tile_repeat),
    .pop_valid             (pop_valid)
  );

  layer_counter u_layer_counter (
    .clk                   (clk),
    .reset                 (reset),
    .i_decoder_done        (i_decoder_done),
    .cfg_loop_iter_v       (cfg_loop_iter_v),
    .cfg_loop_iter_loop_id (cfg_loop_iter_loop_id),
    .layer_one             (layer_one)
  );

  // bias address table and load matching
  bias_addr_history u_history (
    .clk             (clk),
    .reset           (reset),
    .i_decoder_done  (i_decoder_done),
    .cfg_loop_iter_v (cfg_loop_iter_v),
    .round_clear     (round_clear),
    .bias_ld_addr    (bias_ld_addr),
    .base_loop_enter (base_loop_enter),
    .obuf_ld_addr    (obuf_ld_addr),
    .obuf_ld_addr_v  (obuf_ld_addr_v),
    .record_req      (record_req),
    .addr_hit        (addr_hit),
    .late_hit        (late_hit)
  );

  bias_sel_fsm u_sel_fsm (
    .clk               (clk),
    .reset             (reset),
    .tile_repeat       (tile_repeat),
    .pop_valid         (pop_valid),
    .record_req        (record_req),
    .addr_hit          (addr_hit),
    .late_hit          (late_hit),
    .obuf_ld_addr_v    (obuf_ld_addr_v),
    .layer_one         (layer_one),
    .cfg_loop_iter_v   (cfg_loop_iter_v),
    .round_clear       (round_clear),
    .obuf_bias_sel_out (obuf_bias_sel_out)
  );

endmodule

//--- tb_obuf_bias_sel.sv
// ======================================================================
// obuf bias select testbench
// cycle reference model, directed and random stimulus, per-cycle compare
// ======================================================================
`timescale 1ns/1ns

module tb_obuf_bias_sel import obuf_bias_pkg::*; ();

  localparam int directed_cycles = 120;
  localparam int layer_cycles    = 60;
  localparam int random_cycles   = 400;
  // whole run plus margin
  localparam int max_cycles = directed_cycles + layer_cycles + random_cycles + 100;

  logic                   clk;
  logic                   reset;
  logic                   compute_done;
  logic                   i_decoder_done;
  logic                   cfg_loop_iter_v;
  logic [LOOP_ID_W-1:0]   cfg_loop_iter_loop_id;
  logic [TILE_ADDR_W-1:0] obuf_tile_base_addr;
  logic                   obuf_tile_base_addr_v;
  logic [BBUF_ADDR_W-1:0] bias_ld_addr;
  logic                   base_loop_enter;
  logic [OBUF_ADDR_W-1:0] obuf_ld_addr;
  logic                   obuf_ld_addr_v;
  sel_src_e               obuf_bias_sel_out;

  integer   seed;
  int       error_count = 0;
  int       check_count = 0;
  int       cycle_count = 0;
  sel_src_e expected_sel;

  // ======================================================================
  // reference model state
  // ======================================================================

  logic [TILE_ADDR_W-1:0] m_last_tile;
  bit                     m_fifo [$];
  logic                   m_tile_repeat;
  logic                   m_pop_valid;
  logic [LAYER_W-1:0]     m_layer;
  logic [BBUF_ADDR_W-1:0] m_last_bias;
  logic                   m_ble_d;
  logic                   m_fresh;
  logic [HIST_PTR_W-1:0]  m_wr_ptr;
  logic [BBUF_ADDR_W-1:0] m_table [HIST_DEPTH];
  logic                   m_record_d;
  logic [OBUF_ADDR_W-1:0] m_obuf_d;
  logic                   m_skip;
  sel_src_e               m_sel;

  obuf_bias_sel DUT (
    .clk                   (clk),
    .reset                 (reset),
    .compute_done          (compute_done),
    .i_decoder_done        (i_decoder_done),
    .cfg_loop_iter_v       (cfg_loop_iter_v),
    .cfg_loop_iter_loop_id (cfg_loop_iter_loop_id),
    .obuf_tile_base_addr   (obuf_tile_base_addr),
    .obuf_tile_base_addr_v (obuf_tile_base_addr_v),
    .bias_ld_addr          (bias_ld_addr),
    .base_loop_enter       (base_loop_enter),
    .obuf_ld_addr          (obuf_ld_addr),
    .obuf_ld_addr_v        (obuf_ld_addr_v),
    .obuf_bias_sel_out     (obuf_bias_sel_out)
  );

  // steps the whole select rule set by one rising edge and returns the next output
  function automatic sel_src_e model_step();
    logic [HIST_PTR_W-1:0] rd_ptr;
    logic                  push;
    logic                  push_bit;
    logic                  pop;
    logic                  record;
    logic                  hit;
    logic                  late;
    logic                  clear;
    if (reset) begin
      m_last_tile   = '0;
      m_fifo.delete();
      m_tile_repeat = 1'b0;
      m_pop_valid   = 1'b0;
      m_layer       = '0;
      m_last_bias   = '0;
      m_ble_d       = 1'b0;
      m_fresh       = 1'b0;
      m_wr_ptr      = '0;
      m_table[0]    = HIST_SEED_ADDR;
      m_record_d    = 1'b0;
      m_obuf_d      = '0;
      m_skip        = 1'b0;
      m_sel         = SEL_BIAS;
      return SEL_BIAS;
    end
    // terms seen in this cycle
    rd_ptr   = (m_wr_ptr == 0) ? '0 : m_wr_ptr - 1'b1;
    push     = obuf_tile_base_addr_v && (m_last_tile != 0) &&
               (m_fifo.size() < REPEAT_FIFO_DEPTH);
    push_bit = (obuf_tile_base_addr == m_last_tile);
    pop      = compute_done && (m_fifo.size() != 0);
    record   = m_fresh && m_ble_d && (bias_ld_addr == BBUF_ADDR_W'(m_wr_ptr));
    hit      = (obuf_ld_addr == m_table[0]) || (obuf_ld_addr == m_table[rd_ptr]);
    late     = m_record_d && (m_obuf_d == m_table[rd_ptr]) && obuf_ld_addr_v;
    clear    = (m_pop_valid && !m_tile_repeat) || cfg_loop_iter_v;
    // select and skip use the flags before they move
    if (clear || record)
      m_sel = SEL_BIAS;
    else if (m_pop_valid)
      m_sel = sel_src_e'(m_tile_repeat);
    else if (hit && !m_skip)
      m_sel = SEL_OBUF;
    if (obuf_ld_addr_v && (hit || late))
      m_skip = 1'b0;
    else if (record)
      m_skip = 1'b1;
    // history
    if (clear || (bias_ld_addr != m_last_bias))
      m_fresh = 1'b1;
    else if (record)
      m_fresh = 1'b0;
    if (clear) begin
      m_wr_ptr   = '0;
      m_table[0] = HIST_SEED_ADDR;
    end else if (record) begin
      m_table[m_wr_ptr] = bias_ld_addr;
      m_wr_ptr          = m_wr_ptr + 1'b1;
    end
    m_record_d  = record;
    m_obuf_d    = obuf_ld_addr;
    m_ble_d     = base_loop_enter;
    m_last_bias = (i_decoder_done || cfg_loop_iter_v) ? '0 : bias_ld_addr;
    // pop reads the queue head before the push lands
    if (pop)
      m_tile_repeat = m_fifo.pop_front();
    if (push)
      m_fifo.push_back(push_bit);
    m_pop_valid = compute_done;
    if (i_decoder_done || cfg_loop_iter_v)
      m_last_tile = '0;
    else if (obuf_tile_base_addr_v)
      m_last_tile = obuf_tile_base_addr;
    // layer increment beats the clear
    if (cfg_loop_iter_v && (cfg_loop_iter_loop_id == 0))
      m_layer = m_layer + 1'b1;
    else if (i_decoder_done)
      m_layer = '0;
    return (m_layer == 1) ? SEL_BIAS : m_sel;
  endfunction

  task automatic compare_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic drive_idle();
    compute_done          = 1'b0;
    i_decoder_done        = 1'b0;
    cfg_loop_iter_v       = 1'b0;
    cfg_loop_iter_loop_id = '0;
    obuf_tile_base_addr   = '0;
    obuf_tile_base_addr_v = 1'b0;
    bias_ld_addr          = '0;
    base_loop_enter       = 1'b0;
    obuf_ld_addr          = 8'd5;
    obuf_ld_addr_v        = 1'b0;
  endtask

  task automatic send_tile(input logic [TILE_ADDR_W-1:0] addr);
    @(negedge clk);
    obuf_tile_base_addr   = addr;
    obuf_tile_base_addr_v = 1'b1;
    @(negedge clk);
    obuf_tile_base_addr_v = 1'b0;
  endtask

  // compute done pulse and the popped flag two edges later
  task automatic pop_and_expect(input sel_src_e flag);
    @(negedge clk);
    compute_done = 1'b1;
    @(negedge clk);
    compute_done = 1'b0;
    @(negedge clk);
    check_sel_out(flag);
  endtask

  task automatic check_sel_out(input sel_src_e flag);
    compare_value("obuf_bias_sel_out", flag, obuf_bias_sel_out);
  endtask

  task automatic send_cfg(input logic [LOOP_ID_W-1:0] loop_id);
    @(negedge clk);
    cfg_loop_iter_v       = 1'b1;
    cfg_loop_iter_loop_id = loop_id;
    @(negedge clk);
    cfg_loop_iter_v       = 1'b0;
  endtask

  // small ranges so tiles and addresses repeat
  task automatic drive_random(input logic hold_layer);
    compute_done          = ({$random(seed)} % 4) == 0;
    obuf_tile_base_addr   = TILE_ADDR_W'({$random(seed)} % 3 + 1);
    obuf_tile_base_addr_v = ({$random(seed)} % 3) == 0;
    bias_ld_addr          = BBUF_ADDR_W'({$random(seed)} % 4);
    base_loop_enter       = 1'({$random(seed)} % 2);
    obuf_ld_addr          = (({$random(seed)} % 4) == 0) ? HIST_SEED_ADDR :
                            OBUF_ADDR_W'({$random(seed)} % 4);
    obuf_ld_addr_v        = 1'({$random(seed)} % 2);
    cfg_loop_iter_v       = ({$random(seed)} % 16) == 0;
    cfg_loop_iter_loop_id = hold_layer ? LOOP_ID_W'(1) : LOOP_ID_W'({$random(seed)} % 2);
    i_decoder_done        = !hold_layer && (({$random(seed)} % 32) == 0);
  endtask

  // ======================================================================
  // clock, model, compare, timeout
  // ======================================================================

  always #4 clk = ~clk;

  always @(posedge clk) begin
    expected_sel = model_step();
  end

  // registered output is stable at the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      compare_value("obuf_bias_sel_out", expected_sel, obuf_bias_sel_out);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    clk   = 1'b0;
    seed  = 32'hbc58;
    reset = 1'b1;
    drive_idle();
    repeat (2) @(negedge clk);
    reset = 1'b0;
    // idle after reset
    repeat (10) @(negedge clk);
    check_sel_out(SEL_BIAS);
    // tiles A A B B queue flags 1 0 1
    send_tile(42'h3);
    send_tile(42'h3);
    send_tile(42'h7);
    send_tile(42'h7);
    pop_and_expect(SEL_OBUF);
    pop_and_expect(SEL_BIAS);
    pop_and_expect(SEL_OBUF);
    // fresh round records bias 0 and 1 into slots 0 and 1
    send_cfg(5'd2);
    bias_ld_addr    = 8'd0;
    base_loop_enter = 1'b1;
    repeat (3) @(negedge clk);
    bias_ld_addr = 8'd1;
    repeat (3) @(negedge clk);
    base_loop_enter = 1'b0;
    check_sel_out(SEL_BIAS);
    // first hit spends the skip, second one turns the select
    obuf_ld_addr   = 8'd1;
    obuf_ld_addr_v = 1'b1;
    @(negedge clk);
    check_sel_out(SEL_BIAS);
    repeat (2) @(negedge clk);
    check_sel_out(SEL_OBUF);
    obuf_ld_addr_v = 1'b0;
    // round clear reseeds entry 0
    send_cfg(5'd3);
    obuf_ld_addr   = HIST_SEED_ADDR;
    obuf_ld_addr_v = 1'b1;
    repeat (3) @(negedge clk);
    check_sel_out(SEL_OBUF);
    drive_idle();
    // layer one holds the select at bias
    send_cfg(5'd0);
    repeat (layer_cycles) begin
      check_sel_out(SEL_BIAS);
      drive_random(1'b1);
      @(negedge clk);
    end
    drive_idle();
    i_decoder_done = 1'b1;
    @(negedge clk);
    i_decoder_done = 1'b0;
    repeat (5) @(negedge clk);
    // mixed random run
    repeat (random_cycles) begin
      drive_random(1'b0);
      @(negedge clk);
    end
    drive_idle();
    repeat (5) @(negedge clk);
    $display("checks: %0d errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
obuf_bias_pkg.sv
tile_repeat_fifo.sv
tile_repeat_tracker.sv
bias_addr_history.sv
layer_counter.sv
bias_sel_fsm.sv
obuf_bias_sel.sv
tb_obuf_bias_sel.sv
